/* dcachePkg.sv */
// Cache geometry constants and the controller state type that every cache module imports
`default_nettype none

package dcachePkg;

    // address and word geometry
    localparam int addrWidth = 16;
    localparam int wordBytes = 4;
    localparam int wordBits = wordBytes * 8;

    // line geometry
    localparam int blockWords = 4;
    localparam int blockBytes = wordBytes * blockWords;
    localparam int blockBits = blockBytes * 8;

    // offset fields inside the byte address
    localparam int wordOffsetWidth = $clog2(wordBytes);
    localparam int blockOffsetWidth = $clog2(blockBytes);

    // direct-mapped array size
    localparam int lineCount = 16;
    localparam int indexWidth = $clog2(lineCount);

    // tag sits above index and block offset
    localparam int tagWidth = addrWidth - indexWidth - blockOffsetWidth;
    localparam int blockAddrWidth = tagWidth + indexWidth;

    // miss handling sequence of the controller
    typedef enum logic [2:0] {
        idleState,
        writebackState,
        memReadState,
        memCacheState,
        writebackReplaceState
    } cacheState;

endpackage

`default_nettype wire

/* tagStore.sv */
// Valid, dirty and tag arrays of the direct-mapped cache with hit and victim lookup
`timescale 1ns/1ns
`default_nettype none

module tagStore (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [dcachePkg::blockAddrWidth-1:0] blockAddr,
    input  logic                                 fillTag,
    input  logic                                 markDirty,
    output logic                                 hit,
    output logic                                 victimDirty,
    output logic [dcachePkg::blockAddrWidth-1:0] victimBlockAddr
);
    import dcachePkg::*;

    logic [lineCount-1:0] valid;
    logic [lineCount-1:0] dirty;
    logic [tagWidth-1:0] tags [lineCount];
    logic [indexWidth-1:0] index;
    logic [tagWidth-1:0] tag;

    assign index = blockAddr[indexWidth-1:0];
    assign tag = blockAddr[blockAddrWidth-1:indexWidth];

    assign hit = valid[index] && (tags[index] == tag);
    assign victimDirty = valid[index] && dirty[index];
    assign victimBlockAddr = {tags[index], index};

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fillTag) begin
            // freshly fetched line is clean
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (markDirty) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fillTag) begin
            tags[index] <= tag;
        end
    end

    // controller only dirties a resident line
    assertDirtyOnHit: assert property (
        @(posedge clock) disable iff (!reset)
        markDirty |-> hit
    );

endmodule

`default_nettype wire

/* dataStore.sv */
// Line data array of the cache with byte-enabled writes and an asynchronous line read
`timescale 1ns/1ns
`default_nettype none

module dataStore (
    input  logic                              clock,
    input  logic                              cacheWen,
    input  logic [dcachePkg::blockBytes-1:0]  cacheBytesAccess,
    input  logic [dcachePkg::blockBits-1:0]   cacheDin,
    input  logic [dcachePkg::indexWidth-1:0]  index,
    output logic [dcachePkg::blockBits-1:0]   cacheDout
);
    import dcachePkg::*;

    logic [blockBits-1:0] lines [lineCount];

    always_ff @(posedge clock) begin
        if (cacheWen) begin
            for (int b = 0; b < blockBytes; b++) begin
                if (cacheBytesAccess[b]) begin
                    lines[index][b*8 +: 8] <= cacheDin[b*8 +: 8];
                end
            end
        end
    end

    // read path feeds dout and writeback in the same cycle
    assign cacheDout = lines[index];

endmodule

`default_nettype wire

/* mainMemory.sv */
// Line-wide backing memory model with a fixed access latency that serves cache fills and writebacks
`timescale 1ns/1ns
`default_nettype none

module mainMemory #(
    parameter int memLatency = 4
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 memRen,
    input  logic                                 memWen,
    input  logic [dcachePkg::blockAddrWidth-1:0] readAddr,
    input  logic [dcachePkg::blockAddrWidth-1:0] writeAddr,
    input  logic [dcachePkg::blockBits-1:0]      memDin,
    output logic                                 memReadReady,
    output logic                                 memWriteDone,
    output logic [dcachePkg::blockBits-1:0]      memDout
);
    import dcachePkg::*;

    localparam int memLines = 1 << blockAddrWidth;
    localparam int countWidth = (memLatency > 1) ? $clog2(memLatency) : 1;
    localparam logic [countWidth-1:0] lastCount = countWidth'(memLatency - 1);

    logic [blockBits-1:0] lines [memLines];
    logic [countWidth-1:0] count;
    logic busy;
    logic accessDone;

    initial begin
        for (int i = 0; i < memLines; i++) begin
            lines[i] = '0;
        end
    end

    assign busy = memRen || memWen;
    assign accessDone = busy && (count == lastCount);

    assign memReadReady = memRen && accessDone;
    assign memWriteDone = memWen && accessDone;
    assign memDout = lines[readAddr];

    // restarts on every new level and after each completion
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (!busy || accessDone) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always @(posedge clock) begin
        if (memWriteDone) begin
            lines[writeAddr] <= memDin;
        end
    end

    // done is a single-cycle pulse under its own request
    assertReadPulse: assert property (
        @(posedge clock) disable iff (!reset)
        memReadReady |-> memRen ##1 !memReadReady
    );

    assertWritePulse: assert property (
        @(posedge clock) disable iff (!reset)
        memWriteDone |-> memWen ##1 !memWriteDone
    );

endmodule

`default_nettype wire

/* dcacheController.sv */
// Miss FSM and hit steering of the data cache between the pipeline port and the stores
`timescale 1ns/1ns
`default_nettype none

module dcacheController (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 ren,
    input  logic                                 wen,
    input  logic [dcachePkg::addrWidth-1:0]      addr,
    input  logic [dcachePkg::wordBytes-1:0]      byteSelectVector,
    input  logic [dcachePkg::wordBits-1:0]       din,
    input  logic                                 hit,
    input  logic                                 victimDirty,
    input  logic [dcachePkg::blockBits-1:0]      cacheDout,
    input  logic                                 memReadReady,
    input  logic                                 memWriteDone,
    input  logic [dcachePkg::blockBits-1:0]      memDout,
    output logic                                 stall,
    output logic [dcachePkg::wordBits-1:0]       dout,
    output logic [dcachePkg::blockAddrWidth-1:0] blockAddr,
    output logic                                 cacheWen,
    output logic [dcachePkg::blockBytes-1:0]     cacheBytesAccess,
    output logic [dcachePkg::blockBits-1:0]      cacheDin,
    output logic                                 fillTag,
    output logic                                 markDirty,
    output logic                                 memRen,
    output logic                                 memWen,
    output logic [dcachePkg::blockBits-1:0]      memDin
);
    import dcachePkg::*;

    localparam int wordSelWidth = blockOffsetWidth - wordOffsetWidth;

    cacheState state;
    cacheState nextState;
    logic request;
    logic writeReq;
    logic [wordSelWidth-1:0] wordSel;

    assign request = ren ^ wen;
    assign writeReq = wen && !ren;

    assign blockAddr = addr[addrWidth-1:blockOffsetWidth];
    assign wordSel = addr[blockOffsetWidth-1:wordOffsetWidth];

    // read word comes straight from the indexed line
    assign dout = cacheDout[wordSel*wordBits +: wordBits];

    // victim line goes straight out on writeback
    assign memDin = cacheDout;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idleState;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idleState: begin
                if (request && !hit) begin
                    nextState = victimDirty ? writebackState : memReadState;
                end
            end
            writebackState: begin
                if (memWriteDone) begin
                    nextState = memReadState;
                end
            end
            memReadState: begin
                if (memReadReady) begin
                    nextState = memCacheState;
                end
            end
            memCacheState: begin
                // write miss still has to merge the pipeline word
                nextState = writeReq ? writebackReplaceState : idleState;
            end
            writebackReplaceState: begin
                nextState = idleState;
            end
            default: begin
                nextState = idleState;
            end
        endcase
    end

    always_comb begin
        stall = 1'b0;
        cacheWen = 1'b0;
        fillTag = 1'b0;
        markDirty = 1'b0;
        memRen = 1'b0;
        memWen = 1'b0;
        case (state)
            idleState: begin
                // raised in the detect cycle so the pipeline holds
                stall = request && !hit;
                cacheWen = writeReq && hit;
                markDirty = writeReq && hit;
            end
            writebackState: begin
                stall = 1'b1;
                memWen = 1'b1;
            end
            memReadState: begin
                stall = 1'b1;
                memRen = 1'b1;
            end
            memCacheState: begin
                stall = 1'b1;
                cacheWen = 1'b1;
                fillTag = 1'b1;
            end
            writebackReplaceState: begin
                stall = 1'b1;
                cacheWen = 1'b1;
                markDirty = 1'b1;
            end
            default: begin
                stall = 1'b0;
            end
        endcase
    end

    // fill takes the whole line and a hit or merge only one word lane
    always_comb begin
        cacheBytesAccess = '0;
        cacheDin = '0;
        if (state == memCacheState) begin
            cacheBytesAccess = '1;
            cacheDin = memDout;
        end else begin
            cacheBytesAccess[wordSel*wordBytes +: wordBytes] = byteSelectVector;
            cacheDin[wordSel*wordBits +: wordBits] = din;
        end
    end

    assertMemExclusive: assert property (
        @(posedge clock) disable iff (!reset)
        !(memRen && memWen)
    );

    assertMemStalls: assert property (
        @(posedge clock) disable iff (!reset)
        (memRen || memWen) |-> stall
    );

    assertOneRequest: assert property (
        @(posedge clock) disable iff (!reset)
        !(ren && wen)
    );

endmodule

`default_nettype wire

/* dcacheTop.sv */
// Data cache top level that joins controller, stores and backing memory behind the pipeline port
`timescale 1ns/1ns
`default_nettype none

module dcacheTop #(
    parameter int memLatency = 4
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            ren,
    input  logic                            wen,
    input  logic [dcachePkg::addrWidth-1:0] addr,
    input  logic [dcachePkg::wordBytes-1:0] byteSelectVector,
    input  logic [dcachePkg::wordBits-1:0]  din,
    output logic                            stall,
    output logic [dcachePkg::wordBits-1:0]  dout
);
    import dcachePkg::*;

    logic [blockAddrWidth-1:0] blockAddr;
    logic [blockAddrWidth-1:0] victimBlockAddr;
    logic hit;
    logic victimDirty;
    logic fillTag;
    logic markDirty;
    logic cacheWen;
    logic [blockBytes-1:0] cacheBytesAccess;
    logic [blockBits-1:0] cacheDin;
    logic [blockBits-1:0] cacheDout;
    logic memRen;
    logic memWen;
    logic memReadReady;
    logic memWriteDone;
    logic [blockBits-1:0] memDin;
    logic [blockBits-1:0] memDout;

    dcacheController controller (
        .clock(clock), .reset(reset), .ren(ren), .wen(wen), .addr(addr),
        .byteSelectVector(byteSelectVector), .din(din),
        .hit(hit), .victimDirty(victimDirty), .cacheDout(cacheDout),
        .memReadReady(memReadReady), .memWriteDone(memWriteDone), .memDout(memDout),
        .stall(stall), .dout(dout), .blockAddr(blockAddr),
        .cacheWen(cacheWen), .cacheBytesAccess(cacheBytesAccess), .cacheDin(cacheDin),
        .fillTag(fillTag), .markDirty(markDirty),
        .memRen(memRen), .memWen(memWen), .memDin(memDin)
    );

    tagStore tags (
        .clock(clock), .reset(reset), .blockAddr(blockAddr),
        .fillTag(fillTag), .markDirty(markDirty),
        .hit(hit), .victimDirty(victimDirty), .victimBlockAddr(victimBlockAddr)
    );

    // index is the low part of the line address
    dataStore data (
        .clock(clock), .cacheWen(cacheWen), .cacheBytesAccess(cacheBytesAccess),
        .cacheDin(cacheDin), .index(blockAddr[indexWidth-1:0]), .cacheDout(cacheDout)
    );

    mainMemory #(.memLatency(memLatency)) memory (
        .clock(clock), .reset(reset), .memRen(memRen), .memWen(memWen),
        .readAddr(blockAddr), .writeAddr(victimBlockAddr), .memDin(memDin),
        .memReadReady(memReadReady), .memWriteDone(memWriteDone), .memDout(memDout)
    );

endmodule

`default_nettype wire

/* dcacheTb.sv */
// Testbench that drives the data cache pipeline port and checks read data and stall timing
`timescale 1ns/1ns
`default_nettype none

module dcacheTb;
    import dcachePkg::*;

    localparam int memLatency = 3;
    localparam int clockPeriod = 40;
    localparam int missCycles = 2 * memLatency + 5;
    localparam int opCount = 230;
    localparam int watchdogTime = opCount * (missCycles + 1) * clockPeriod * 2;

    logic clock;
    logic reset;
    logic ren;
    logic wen;
    logic [addrWidth-1:0] addr;
    logic [wordBytes-1:0] byteSelectVector;
    logic [wordBits-1:0] din;
    logic stall;
    logic [wordBits-1:0] dout;

    // byte shadow of memory and residency of each line
    logic [7:0] shadow [1 << addrWidth];
    logic lineValid [lineCount];
    logic [tagWidth-1:0] lineTag [lineCount];

    // expectations that travel with the request
    logic [wordBits-1:0] expectedWord;
    logic expectHit;
    logic fresh;

    int unsigned seed;
    int errorCount;
    int readCount;
    int testCount;
    int failedTests;
    int testErrors;

    dcacheTop #(.memLatency(memLatency)) UUT (
        .clock(clock), .reset(reset), .ren(ren), .wen(wen), .addr(addr),
        .byteSelectVector(byteSelectVector), .din(din), .stall(stall), .dout(dout)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin
        #(watchdogTime);
        $display("timeout: the cache did not finish %0d operations in time", opCount);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'h0000, seed[31:16]};
    endfunction

    function automatic logic [addrWidth-1:0] makeAddr(input logic [tagWidth-1:0] tag,
                                                      input logic [indexWidth-1:0] idx,
                                                      input logic [1:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    // drives one request at a rising edge and returns at the edge where it completes
    task automatic access(input logic isWrite, input logic [addrWidth-1:0] a,
                          input logic [wordBytes-1:0] be, input logic [wordBits-1:0] d);
        logic [indexWidth-1:0] idx;
        logic [tagWidth-1:0] tag;
        logic [addrWidth-1:0] base;
        logic done;
        idx = a[blockOffsetWidth +: indexWidth];
        tag = a[addrWidth-1 -: tagWidth];
        base = {a[addrWidth-1:wordOffsetWidth], 2'b00};
        ren <= !isWrite;
        wen <= isWrite;
        addr <= a;
        byteSelectVector <= be;
        din <= d;
        expectedWord <= {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
        expectHit <= lineValid[idx] && (lineTag[idx] == tag);
        fresh <= 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            done = !stall;
            @(posedge clock);
            fresh <= 1'b0;
        end
        if (isWrite) begin
            for (int i = 0; i < wordBytes; i++) begin
                if (be[i]) begin
                    shadow[base+i] = d[i*8 +: 8];
                end
            end
        end else begin
            readCount++;
        end
        lineValid[idx] = 1'b1;
        lineTag[idx] = tag;
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    // closes a test with one idle cycle and prints its result
    task automatic finishTest(input string name);
        @(posedge clock);
        testCount++;
        if (errorCount != testErrors) begin
            failedTests++;
        end
        $display("test %0d %s: %s", testCount, name,
                 (errorCount == testErrors) ? "passed" : "failed");
        testErrors = errorCount;
    endtask

    checkIdleStall: assert property (
        @(posedge clock) disable iff (!reset)
        !(ren || wen) |-> !stall
    ) else begin
        errorCount++;
        $display("[FAIL] t=%0t stall expected 0 actual %0b", $time, $sampled(stall));
    end

    checkHitNoStall: assert property (
        @(posedge clock) disable iff (!reset)
        (fresh && expectHit) |-> !stall
    ) else begin
        errorCount++;
        $display("[FAIL] t=%0t stall expected 0 actual %0b", $time, $sampled(stall));
    end

    checkMissStalls: assert property (
        @(posedge clock) disable iff (!reset)
        (fresh && !expectHit) |-> stall
    ) else begin
        errorCount++;
        $display("[FAIL] t=%0t stall expected 1 actual %0b", $time, $sampled(stall));
    end

    checkReadData: assert property (
        @(posedge clock) disable iff (!reset)
        (ren && !stall) |-> (dout == expectedWord)
    ) else begin
        errorCount++;
        $display("[FAIL] t=%0t dout expected %h actual %h", $time,
                 $sampled(expectedWord), $sampled(dout));
    end

    checkStallBound: assert property (
        @(posedge clock) disable iff (!reset)
        $rose(stall) |-> ##[1:missCycles] !stall
    ) else begin
        errorCount++;
        $display("stall stayed high longer than %0d cycles at t=%0t", missCycles, $time);
    end

    initial begin
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [tagWidth-1:0] tag;
        logic [addrWidth-1:0] a;
        reset = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        addr = '0;
        byteSelectVector = '0;
        din = '0;
        expectedWord = '0;
        expectHit = 1'b0;
        fresh = 1'b0;
        seed = 33;
        errorCount = 0;
        readCount = 0;
        testCount = 0;
        failedTests = 0;
        testErrors = 0;
        for (int i = 0; i < (1 << addrWidth); i++) begin
            shadow[i] = 8'h00;
        end
        for (int i = 0; i < lineCount; i++) begin
            lineValid[i] = 1'b0;
            lineTag[i] = '0;
        end
        repeat (2) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);

        repeat (3) @(posedge clock);
        access(1'b0, makeAddr(8'h01, 4'h0, 2'd1), 4'h0, 32'h0);
        finishTest("stall after reset");

        a = makeAddr(8'h02, 4'h3, 2'd2);
        access(1'b1, a, 4'b1111, 32'hA1B2C3D4);
        access(1'b1, a, 4'b0010, 32'h00005500);
        access(1'b1, a, 4'b1000, 32'h77000000);
        access(1'b1, a, 4'b0001, 32'h00000011);
        access(1'b0, a, 4'h0, 32'h0);
        finishTest("write then read hit");

        access(1'b0, makeAddr(8'h05, 4'h7, 2'd0), 4'h0, 32'h0);
        access(1'b0, makeAddr(8'h05, 4'h7, 2'd3), 4'h0, 32'h0);
        finishTest("clean read miss");

        a = makeAddr(8'h06, 4'hC, 2'd1);
        access(1'b1, a, 4'b1111, 32'hDEADBEEF);
        access(1'b0, makeAddr(8'h09, 4'hC, 2'd1), 4'h0, 32'h0);
        access(1'b0, a, 4'h0, 32'h0);
        finishTest("dirty eviction");

        // word 2 goes out to memory before the write miss on word 0
        access(1'b1, makeAddr(8'h0A, 4'h9, 2'd2), 4'b1111, 32'h12345678);
        access(1'b0, makeAddr(8'h0B, 4'h9, 2'd0), 4'h0, 32'h0);
        access(1'b1, makeAddr(8'h0A, 4'h9, 2'd0), 4'b0101, 32'hCAFEF00D);
        for (int w = 0; w < blockWords; w++) begin
            access(1'b0, makeAddr(8'h0A, 4'h9, 2'(w)), 4'h0, 32'h0);
        end
        finishTest("write miss allocate");

        for (int i = 0; i < 200; i++) begin
            r = nextRandom();
            hi = nextRandom();
            lo = nextRandom();
            tag = 8'(8'h41 + r % 3);
            a = makeAddr(tag, r[7:4], r[9:8]);
            access(r[14], a, r[13:10], {hi[15:0], lo[15:0]});
        end
        finishTest("random mix");

        $display("tests %0d, failed tests %0d, reads checked %0d, errors %0d",
                 testCount, failedTests, readCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
dcachePkg.sv
tagStore.sv
dataStore.sv
mainMemory.sv
dcacheController.sv
dcacheTop.sv
dcacheTb.sv
